/* edge_ram.sv */
`timescale 1ns/100ps

module edge_ram #(
  parameter int DEPTH = pixels_pkg::RAM_EDGES_DEPTH,
  parameter int WIDTH = pixels_pkg::WORD_WIDTH_DEF
) (
  input  logic                     aclk,
  input  logic                     i_en,
  input  logic                     i_we,
  input  logic [$clog2(DEPTH)-1:0] i_addr,
  input  logic [WIDTH-1:0]         i_din,
  output logic [WIDTH-1:0]         o_dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read data keeps its value during a write
  always_ff @(posedge aclk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_din;
      end else begin
        o_dout <= mem[i_addr];
      end
    end
  end

endmodule

/* list.f */
pixels_pkg.sv
stream_width_adapter.sv
loop_counter.sv
edge_ram.sv
window_shifter.sv
pixel_stream_top.sv
tb_pixel_stream.sv

/* loop_counter.sv */
`timescale 1ns/100ps

module loop_counter #(
  parameter int W = pixels_pkg::BITS_KH
) (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         i_load,
  input  logic         i_en,
  input  logic [W-1:0] i_max,
  output logic [W-1:0] o_count,
  output logic         o_first,
  output logic         o_last,
  output logic         o_last_clk
);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_count <= '0;
    end else if (i_load) begin
      o_count <= '0;
    end else if (i_en) begin
      // Wrap after the terminal value
      o_count <= o_last ? '0 : o_count + 1'b1;
    end
  end

  assign o_first    = o_count == '0;
  assign o_last     = o_count == i_max;
  assign o_last_clk = o_last && i_en;

endmodule

/* pixel_stream_top.sv */
`timescale 1ns/100ps

module pixel_stream_top #(
  parameter int ROWS       = pixels_pkg::ROWS_DEF,
  parameter int KH_MAX     = pixels_pkg::KH_MAX_DEF,
  parameter int WORD_WIDTH = pixels_pkg::WORD_WIDTH_DEF,
  parameter int S_WORDS    = pixels_pkg::S_WORDS_DEF,
  parameter int CI_MAX     = pixels_pkg::CI_MAX_DEF,
  parameter int XW_MAX     = pixels_pkg::XW_MAX_DEF,
  parameter int BLOCKS_MAX = pixels_pkg::BLOCKS_MAX_DEF
) (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_s_valid,
  output logic                              o_s_ready,
  input  logic                              i_s_last,
  input  logic [S_WORDS-1:0][WORD_WIDTH-1:0] i_s_data,
  input  logic [S_WORDS-1:0]                i_s_keep,
  output logic                              o_m_valid,
  input  logic                              i_m_ready,
  output logic [ROWS-1:0][WORD_WIDTH-1:0]    o_m_data,
  output logic                              o_m_last
);

  localparam int EDGE_WORDS  = KH_MAX / 2;
  localparam int EL_WORDS    = ROWS + EDGE_WORDS;
  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_KH2    = $clog2(EDGE_WORDS + 1);
  localparam int BITS_CI     = $clog2(CI_MAX);
  localparam int BITS_XW     = $clog2(XW_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);
  localparam int RAM_DEPTH   = CI_MAX * XW_MAX;
  localparam int BITS_ADDR   = $clog2(RAM_DEPTH);

  localparam logic [1:0] SET   = 2'd0;
  localparam logic [1:0] PASS  = 2'd1;
  localparam logic [1:0] BLOCK = 2'd2;

  logic [1:0]              state;
  pixels_pkg::pixel_beat_u hdr;
  logic [BITS_KH2-1:0]     kh2_in, kh2_r;
  logic [BITS_CI-1:0]      ci_m1_r;
  logic [BITS_XW-1:0]      w_m1_r;
  logic [BITS_BLOCKS-1:0]  blocks_m1_r;
  logic [BITS_KH-1:0]      kh_max;
  logic use_halo, cfg_load, en_kh, en_copy, en_shift;
  logic in_last_beat, out_last_beat;

  logic row_s_valid, row_s_ready, row_m_valid, row_m_ready, row_m_last;
  logic halo_s_valid, halo_s_ready, halo_m_valid, halo_m_ready, halo_m_last;
  logic [ROWS-1:0][WORD_WIDTH-1:0]     row_m_data;
  logic [EL_WORDS-1:0][WORD_WIDTH-1:0] halo_m_data, elem_data, data_r;
  logic elem_valid, elem_last;

  logic last_kh, last_clk_kh, last_clk_ci, last_clk_w, first_blk, last_blk;
  logic copy_r, valid_r, last_r, last_kh_r, last_clk_kh_r, first_blk_r, last_blk_r;
  logic m_last_reg;

  logic [BITS_ADDR-1:0] ram_addr, addr_r, ram_addr_in;
  logic ram_ren, ram_wen, ren_r;
  logic [EDGE_WORDS-1:0][WORD_WIDTH-1:0] ram_dout, ram_hold, edge_top, edge_bot;

  // Header decode
  assign hdr    = i_s_data;
  assign kh2_in = (int'(hdr.header.kh2) > EDGE_WORDS) ? '0 : BITS_KH2'(hdr.header.kh2);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      kh2_r       <= '0;
      ci_m1_r     <= '0;
      w_m1_r      <= '0;
      blocks_m1_r <= '0;
    end else if (cfg_load && i_s_valid) begin
      kh2_r       <= kh2_in;
      ci_m1_r     <= BITS_CI'(hdr.header.ci_m1);
      w_m1_r      <= BITS_XW'(hdr.header.w_m1);
      blocks_m1_r <= BITS_BLOCKS'(hdr.header.blocks_m1);
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= SET;
    end else begin
      case (state)
        SET:     if (i_s_valid) state <= PASS;
        PASS:    if (in_last_beat) state <= out_last_beat ? SET : BLOCK;
        BLOCK:   if (out_last_beat) state <= SET;
        default: state <= SET;
      endcase
    end
  end

  assign cfg_load      = state == SET;
  assign use_halo      = kh2_r != '0;
  assign kh_max        = BITS_KH'(2 * kh2_r);
  assign in_last_beat  = (state == PASS) && i_s_valid && o_s_ready && i_s_last;
  assign out_last_beat = o_m_valid && i_m_ready && o_m_last;

  assign en_shift = !cfg_load && i_m_ready;
  // Kernel waits on its last step until a new element or the drain
  assign en_kh    = en_shift && (!last_kh || elem_valid || m_last_reg || last_r);
  assign en_copy  = elem_valid && last_clk_kh;

  // Input goes to the adapter picked by kh2
  always_comb begin
    o_s_ready    = 1'b0;
    row_s_valid  = 1'b0;
    halo_s_valid = 1'b0;
    if (state == SET) begin
      o_s_ready = 1'b1;
    end else if (state == PASS) begin
      o_s_ready    = use_halo ? halo_s_ready : row_s_ready;
      row_s_valid  = i_s_valid && !use_halo;
      halo_s_valid = i_s_valid && use_halo;
    end
  end

  stream_width_adapter #(
    .S_WORDS    (S_WORDS),
    .M_WORDS    (ROWS),
    .WORD_WIDTH (WORD_WIDTH)
  ) row_adapter (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (row_s_valid),
    .o_s_ready (row_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_m_valid (row_m_valid),
    .i_m_ready (row_m_ready),
    .o_m_data  (row_m_data),
    .o_m_last  (row_m_last)
  );

  stream_width_adapter #(
    .S_WORDS    (S_WORDS),
    .M_WORDS    (EL_WORDS),
    .WORD_WIDTH (WORD_WIDTH)
  ) halo_adapter (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (halo_s_valid),
    .o_s_ready (halo_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_m_valid (halo_m_valid),
    .i_m_ready (halo_m_ready),
    .o_m_data  (halo_m_data),
    .o_m_last  (halo_m_last)
  );

  assign elem_valid   = use_halo ? halo_m_valid : row_m_valid;
  assign elem_last    = use_halo ? halo_m_last : row_m_last;
  assign elem_data    = use_halo ? halo_m_data
                                 : {{(EDGE_WORDS * WORD_WIDTH){1'b0}}, row_m_data};
  assign row_m_ready  = en_copy && !use_halo;
  assign halo_m_ready = en_copy && use_halo;

  // Loops: kernel, channel, width, block
  loop_counter #(.W(BITS_KH)) counter_kh (
    .aclk (aclk), .aresetn (aresetn), .i_load (cfg_load), .i_en (en_kh), .i_max (kh_max),
    .o_count (), .o_first (), .o_last (last_kh), .o_last_clk (last_clk_kh)
  );

  loop_counter #(.W(BITS_CI)) counter_ci (
    .aclk (aclk), .aresetn (aresetn), .i_load (cfg_load), .i_en (last_clk_kh),
    .i_max (ci_m1_r), .o_count (), .o_first (), .o_last (), .o_last_clk (last_clk_ci)
  );

  loop_counter #(.W(BITS_XW)) counter_w (
    .aclk (aclk), .aresetn (aresetn), .i_load (cfg_load), .i_en (last_clk_ci),
    .i_max (w_m1_r), .o_count (), .o_first (), .o_last (), .o_last_clk (last_clk_w)
  );

  loop_counter #(.W(BITS_BLOCKS)) counter_blocks (
    .aclk (aclk), .aresetn (aresetn), .i_load (cfg_load), .i_en (last_clk_w),
    .i_max (blocks_m1_r), .o_count (), .o_first (first_blk), .o_last (last_blk),
    .o_last_clk ()
  );

  // Column/channel position within the block row
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ram_addr <= '0;
    end else if (cfg_load || last_clk_w) begin
      ram_addr <= '0;
    end else if (en_copy) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  // Pipeline stage matching the RAM read latency
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      copy_r        <= 1'b0;
      valid_r       <= 1'b0;
      last_r        <= 1'b0;
      last_kh_r     <= 1'b0;
      last_clk_kh_r <= 1'b0;
      first_blk_r   <= 1'b0;
      last_blk_r    <= 1'b0;
    end else if (en_shift) begin
      copy_r        <= en_copy;
      valid_r       <= elem_valid;
      last_r        <= elem_last;
      last_kh_r     <= last_kh;
      last_clk_kh_r <= last_clk_kh;
      first_blk_r   <= first_blk;
      last_blk_r    <= last_blk;
    end
  end

  always_ff @(posedge aclk) begin
    if (en_shift) begin
      data_r <= elem_data;
      addr_r <= ram_addr;
    end
  end

  assign ram_ren     = en_copy && !first_blk;
  assign ram_wen     = copy_r && !last_blk_r;
  assign ram_addr_in = ram_wen ? addr_r : ram_addr;
  assign edge_bot    = data_r[ROWS-1:ROWS-EDGE_WORDS];

  edge_ram #(
    .DEPTH (RAM_DEPTH),
    .WIDTH (EDGE_WORDS * WORD_WIDTH)
  ) edge_store (
    .aclk   (aclk),
    .i_en   (ram_ren || ram_wen),
    .i_we   (ram_wen),
    .i_addr (ram_addr_in),
    .i_din  (edge_bot),
    .o_dout (ram_dout)
  );

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ren_r <= 1'b0;
    end else begin
      ren_r <= ram_ren;
    end
  end

  // Keep read data while the shifter is stalled
  always_ff @(posedge aclk) begin
    if (ren_r) begin
      ram_hold <= ram_dout;
    end
  end

  assign edge_top = first_blk_r ? '0 : (ren_r ? ram_dout : ram_hold);

  window_shifter #(
    .ROWS       (ROWS),
    .EDGE_WORDS (EDGE_WORDS),
    .WORD_WIDTH (WORD_WIDTH)
  ) shifter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_shift_en (en_shift),
    .i_load     (copy_r),
    .i_element  (data_r),
    .i_edge_top (edge_top),
    .i_kh2      (kh2_r),
    .o_window   (o_m_data)
  );

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_m_valid  <= 1'b0;
      m_last_reg <= 1'b0;
    end else if (out_last_beat) begin
      o_m_valid  <= 1'b0;
      m_last_reg <= 1'b0;
    end else begin
      if (copy_r && en_shift) begin
        m_last_reg <= last_r;
      end
      if (last_kh_r && en_shift) begin
        o_m_valid <= valid_r;
      end
    end
  end

  // Last window of the last element
  assign o_m_last = m_last_reg && last_clk_kh_r;

endmodule

/* pixels_pkg.sv */
package pixels_pkg;

  localparam int ROWS_DEF       = 4;
  localparam int KH_MAX_DEF     = 3;
  localparam int WORD_WIDTH_DEF = 8;
  localparam int S_WORDS_DEF    = 4;
  localparam int CI_MAX_DEF     = 4;
  localparam int XW_MAX_DEF     = 8;
  localparam int BLOCKS_MAX_DEF = 4;

  // Halo words on each side of a block
  localparam int EDGE_WORDS = KH_MAX_DEF / 2;

  localparam int BITS_KH     = $clog2(KH_MAX_DEF);
  localparam int BITS_KH2    = $clog2(EDGE_WORDS + 1);
  localparam int BITS_CI     = $clog2(CI_MAX_DEF);
  localparam int BITS_XW     = $clog2(XW_MAX_DEF);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX_DEF);

  // One edge word per column and channel
  localparam int RAM_EDGES_DEPTH = CI_MAX_DEF * XW_MAX_DEF;

  localparam int BEAT_BITS = S_WORDS_DEF * WORD_WIDTH_DEF;
  localparam int HDR_PAD   = BEAT_BITS - BITS_BLOCKS - BITS_XW - BITS_CI - BITS_KH2;

  // Input beat seen as pixel words or as the image header
  typedef union packed {
    logic [S_WORDS_DEF-1:0][WORD_WIDTH_DEF-1:0] words;
    struct packed {
      logic [HDR_PAD-1:0]     pad;
      logic [BITS_BLOCKS-1:0] blocks_m1;
      logic [BITS_XW-1:0]     w_m1;
      logic [BITS_CI-1:0]     ci_m1;
      logic [BITS_KH2-1:0]    kh2;
    } header;
  } pixel_beat_u;

endpackage

/* stream_width_adapter.sv */
`timescale 1ns/100ps

module stream_width_adapter #(
  parameter int S_WORDS    = pixels_pkg::S_WORDS_DEF,
  parameter int M_WORDS    = pixels_pkg::ROWS_DEF,
  parameter int WORD_WIDTH = pixels_pkg::WORD_WIDTH_DEF
) (
  input  logic                              aclk,
  input  logic                              aresetn,
  input  logic                              i_s_valid,
  output logic                              o_s_ready,
  input  logic                              i_s_last,
  input  logic [S_WORDS-1:0][WORD_WIDTH-1:0] i_s_data,
  input  logic [S_WORDS-1:0]                i_s_keep,
  output logic                              o_m_valid,
  input  logic                              i_m_ready,
  output logic [M_WORDS-1:0][WORD_WIDTH-1:0] o_m_data,
  output logic                              o_m_last
);

  localparam int CAP = M_WORDS + S_WORDS;
  localparam int CW  = $clog2(CAP + S_WORDS + 1);

  logic [CAP-1:0][WORD_WIDTH-1:0] buf_q, buf_n;
  logic [CW-1:0] fill_q, fill_n, fill_kept;
  logic [CW-1:0] left_q, left_n;
  logic          pend_q, pend_n;
  logic          push, pop;

  assign o_m_valid = fill_q >= CW'(M_WORDS);
  assign o_m_data  = buf_q[M_WORDS-1:0];
  // Group closes the packet when exactly its words remain
  assign o_m_last  = o_m_valid && pend_q && (left_q == CW'(M_WORDS));

  assign pop       = o_m_valid && i_m_ready;
  assign fill_kept = pop ? fill_q - CW'(M_WORDS) : fill_q;
  assign o_s_ready = (fill_kept + CW'(S_WORDS)) <= CW'(CAP);
  assign push      = i_s_valid && o_s_ready;

  always_comb begin
    buf_n  = buf_q;
    fill_n = fill_kept;
    pend_n = pend_q;
    left_n = left_q;
    if (pop) begin
      buf_n  = buf_q >> (M_WORDS * WORD_WIDTH);
      left_n = left_q - CW'(M_WORDS);
      if (o_m_last) begin
        pend_n = 1'b0;
      end
    end
    if (push) begin
      // Append kept words in order
      for (int i = 0; i < S_WORDS; i++) begin
        if (i_s_keep[i]) begin
          buf_n[fill_n] = i_s_data[i];
          fill_n        = fill_n + 1'b1;
        end
      end
      if (i_s_last) begin
        pend_n = 1'b1;
        left_n = fill_n;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      fill_q <= '0;
      pend_q <= 1'b0;
      left_q <= '0;
    end else begin
      fill_q <= fill_n;
      pend_q <= pend_n;
      left_q <= left_n;
    end
  end

  always_ff @(posedge aclk) begin
    buf_q <= buf_n;
  end

endmodule

/* tb_pixel_stream.sv */
`timescale 1ns/100ps

module tb_pixel_stream;

  localparam int ROWS        = pixels_pkg::ROWS_DEF;
  localparam int WW          = pixels_pkg::WORD_WIDTH_DEF;
  localparam int S_WORDS     = pixels_pkg::S_WORDS_DEF;
  localparam int BITS_KH2    = pixels_pkg::BITS_KH2;
  localparam int BITS_CI     = pixels_pkg::BITS_CI;
  localparam int BITS_XW     = pixels_pkg::BITS_XW;
  localparam int BITS_BLOCKS = pixels_pkg::BITS_BLOCKS;
  localparam int BEAT_W      = S_WORDS * WW;
  localparam int WIN_W       = ROWS * WW;
  localparam int HALF        = 50;
  localparam int SETTLE      = 40;

  logic                         aclk;
  logic                         aresetn;
  logic                         i_s_valid;
  logic                         o_s_ready;
  logic                         i_s_last;
  logic [S_WORDS-1:0][WW-1:0]   i_s_data;
  logic [S_WORDS-1:0]           i_s_keep;
  logic                         o_m_valid;
  logic                         i_m_ready;
  logic [ROWS-1:0][WW-1:0]      o_m_data;
  logic                         o_m_last;

  int               seed;
  int               cycles;
  int               limit;
  bit               rand_ready;
  bit               ready_pat [256];
  string            test_name;
  logic [WW-1:0]    pix [0:1023];
  logic [WIN_W-1:0] exp_data [$];
  bit               exp_last [$];

  pixel_stream_top DUT (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #HALF aclk = ~aclk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [WIN_W-1:0] expected,
                             input logic [WIN_W-1:0] actual);
    if (actual !== expected) begin
      fail_now($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual));
    end
  endtask

  // Windows per element from top halo, rows and bottom halo
  function automatic void build_expected(input int kh2, input int nci, input int nw,
                                         input int nblk);
    int               ew;
    int               plane;
    int               ne;
    logic [WW-1:0]    col [0:ROWS+1];
    logic [WIN_W-1:0] win;
    ew    = ROWS + kh2;
    plane = nw * nci;
    ne    = nblk * plane;
    for (int e = 0; e < ne; e++) begin
      // Top halo is the last row one block up
      col[0] = (e < plane) ? '0 : pix[(e - plane) * ew + ROWS - 1];
      for (int r = 0; r <= ROWS; r++) begin
        col[r + 1] = (r < ew) ? pix[e * ew + r] : '0;
      end
      for (int k = 0; k <= 2 * kh2; k++) begin
        for (int r = 0; r < ROWS; r++) begin
          win[r * WW +: WW] = col[r + k + 1 - kh2];
        end
        exp_data.push_back(win);
        exp_last.push_back((e == ne - 1) && (k == 2 * kh2));
      end
    end
  endfunction

  task automatic send_beat(input logic [BEAT_W-1:0] data, input logic [S_WORDS-1:0] keep,
                           input logic last, input bit gaps);
    @(negedge aclk);
    while (gaps && (($random(seed) & 3) == 0)) begin
      i_s_valid = 1'b0;
      @(negedge aclk);
    end
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_keep  = keep;
    i_s_last  = last;
    #SETTLE;
    while (!o_s_ready) begin
      @(negedge aclk);
      #SETTLE;
    end
  endtask

  task automatic send_image(input int kh2, input int nci, input int nw, input int nblk,
                            input bit gaps);
    pixels_pkg::pixel_beat_u beat;
    logic [S_WORDS-1:0]      keep;
    int                      nwords;
    int                      nbeats;
    int                      idx;
    nwords = nblk * nw * nci * (ROWS + kh2);
    nbeats = (nwords + S_WORDS - 1) / S_WORDS;
    for (int i = 0; i < nwords; i++) begin
      pix[i] = $random(seed);
    end
    build_expected(kh2, nci, nw, nblk);
    limit = limit + 8 * nblk * nw * nci * (2 * kh2 + 1) + 4 * (nbeats + 1);
    beat                  = '0;
    beat.header.kh2       = BITS_KH2'(kh2);
    beat.header.ci_m1     = BITS_CI'(nci - 1);
    beat.header.w_m1      = BITS_XW'(nw - 1);
    beat.header.blocks_m1 = BITS_BLOCKS'(nblk - 1);
    send_beat(beat, '1, 1'b0, gaps);
    for (int b = 0; b < nbeats; b++) begin
      beat = '0;
      keep = '0;
      for (int i = 0; i < S_WORDS; i++) begin
        idx = b * S_WORDS + i;
        if (idx < nwords) begin
          beat.words[i] = pix[idx];
          keep[i]       = 1'b1;
        end
      end
      send_beat(beat, keep, b == nbeats - 1, gaps);
    end
    @(negedge aclk);
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(negedge aclk);
    end
  endtask

  initial begin : drive_ready
    forever begin
      @(negedge aclk);
      i_m_ready = rand_ready ? ready_pat[cycles % 256] : 1'b1;
    end
  end

  // Every output transfer against the model
  initial begin : compare_outputs
    forever begin
      @(negedge aclk);
      #SETTLE;
      if (o_m_valid === 1'b1 && i_m_ready === 1'b1) begin
        if (exp_data.size() == 0) begin
          fail_now("Output window arrived while no window was expected");
        end
        check_value("window", exp_data.pop_front(), o_m_data);
        check_value("last", exp_last.pop_front(), o_m_last);
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge aclk);
      cycles = cycles + 1;
      if (cycles > limit) begin
        fail_now($sformatf("Timeout after %0d cycles with %0d windows still expected",
                           cycles, exp_data.size()));
      end
    end
  end

  initial begin : main
    seed       = 32'h758f_94d7;
    cycles     = 0;
    limit      = 500;
    rand_ready = 1'b0;
    aresetn    = 1'b0;
    i_s_valid  = 1'b0;
    i_s_last   = 1'b0;
    i_s_data   = '0;
    i_s_keep   = '0;
    i_m_ready  = 1'b1;
    for (int i = 0; i < 256; i++) begin
      ready_pat[i] = ($random(seed) & 3) != 0;
    end
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    test_name = "reset";
    #SETTLE;
    check_value("o_m_valid", 1'b0, o_m_valid);
    check_value("o_m_last", 1'b0, o_m_last);
    check_value("o_s_ready", 1'b1, o_s_ready);

    test_name = "kh2_0_image";
    send_image(0, 2, 3, 2, 1'b0);
    wait_drain();

    // 90 words, so the final beat keeps two
    test_name = "kh2_1_image";
    send_image(1, 2, 3, 3, 1'b0);
    wait_drain();

    test_name = "back_to_back";
    send_image(1, 1, 2, 2, 1'b0);
    send_image(0, 3, 2, 2, 1'b0);
    wait_drain();

    test_name  = "random_flow";
    rand_ready = 1'b1;
    send_image(1, 4, 8, 4, 1'b1);
    send_image(1, 3, 3, 1, 1'b1);
    send_image(0, 3, 5, 3, 1'b1);
    wait_drain();

    @(negedge aclk);
    if (exp_data.size() == 0 && o_m_valid === 1'b0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_now("DUT still had an output window pending after the last image");
    end
  end

endmodule

/* window_shifter.sv */
`timescale 1ns/100ps

module window_shifter #(
  parameter  int ROWS       = pixels_pkg::ROWS_DEF,
  parameter  int EDGE_WORDS = pixels_pkg::EDGE_WORDS,
  parameter  int WORD_WIDTH = pixels_pkg::WORD_WIDTH_DEF,
  localparam int BITS_KH2   = $clog2(EDGE_WORDS + 1)
) (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic                                      i_shift_en,
  input  logic                                      i_load,
  input  logic [ROWS+EDGE_WORDS-1:0][WORD_WIDTH-1:0] i_element,
  input  logic [EDGE_WORDS-1:0][WORD_WIDTH-1:0]      i_edge_top,
  input  logic [BITS_KH2-1:0]                       i_kh2,
  output logic [ROWS-1:0][WORD_WIDTH-1:0]            o_window
);

  // Top halo, rows, bottom halo
  localparam int REGS = ROWS + 2 * EDGE_WORDS;

  logic [REGS-1:0][WORD_WIDTH-1:0] shift_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      shift_q <= '0;
    end else if (i_shift_en && i_load) begin
      shift_q <= {i_element, i_edge_top};
    end else if (i_shift_en) begin
      // One row down per output window
      shift_q <= shift_q >> WORD_WIDTH;
    end
  end

  // kh2 = 0 starts past the top halo
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      o_window[r] = shift_q[r + EDGE_WORDS - int'(i_kh2)];
    end
  end

endmodule
